//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_mrelbp_ci_top -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+tests
common/mrelbp_pkg.sv
hw/r4_line_buffer.sv
ci_r4/r4_sum.sv
ci_r4/r4_controller.sv
ci_r4/mrelbp_ci_r4.sv
hw/mrelbp_ci_top.sv
tests/tb_mrelbp_ci_top.sv

//--- ci_r4/mrelbp_ci_r4.sv
`timescale 1ns/1ps

module mrelbp_ci_r4 (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 col_valid,
  input  mrelbp_pkg::pix_col_t col,
  output logic                 ci_valid,
  output logic                 ci,
  output logic                 row_done,
  output logic                 frame_done
);

  logic                col_full;
  logic                col_last;
  logic                row_last;
  logic                win_en;
  logic                win_strobe;
  logic                clr;
  logic                sum_row_done;
  logic                sum_frame_done;
  mrelbp_pkg::winsum_t win_sum;
  mrelbp_pkg::pix_t    centre;
  mrelbp_pkg::scaled_t scaled_q;
  mrelbp_pkg::winsum_t sum_q;

  r4_controller u_controller (
    .clk        (clk),
    .rst_n      (rst_n),
    .col_valid  (col_valid),
    .col_full   (col_full),
    .col_last   (col_last),
    .row_last   (row_last),
    .win_en     (win_en),
    .win_strobe (win_strobe),
    .clr        (clr),
    .row_done   (sum_row_done),
    .frame_done (sum_frame_done)
  );

  r4_sum u_sum (
    .clk       (clk),
    .rst_n     (rst_n),
    .col_valid (col_valid),
    .col       (col),
    .win_en    (win_en),
    .clr       (clr),
    .col_full  (col_full),
    .col_last  (col_last),
    .row_last  (row_last),
    .win_sum   (win_sum),
    .centre    (centre)
  );

  always_ff @(posedge clk) begin
    scaled_q <= mrelbp_pkg::scaled_t'(centre) * mrelbp_pkg::scaled_t'(mrelbp_pkg::win_area);
    sum_q    <= win_sum;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ci_valid   <= 1'b0;
      row_done   <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      ci_valid   <= win_strobe;
      row_done   <= sum_row_done;
      frame_done <= sum_frame_done;
    end
  end

  assign ci = !(scaled_q < sum_q);  // Centre at least the mean

endmodule

//--- ci_r4/r4_controller.sv
`timescale 1ns/1ps

module r4_controller (
  input  logic clk,
  input  logic rst_n,
  input  logic col_valid,
  input  logic col_full,
  input  logic col_last,
  input  logic row_last,
  output logic win_en,
  output logic win_strobe,
  output logic clr,
  output logic row_done,
  output logic frame_done
);

  mrelbp_pkg::ci_state_t state;
  mrelbp_pkg::ci_state_t state_next;

  // The column that fills the window already counts
  assign win_en = col_valid &&
                  (state == mrelbp_pkg::run ||
                   (state == mrelbp_pkg::fill && col_full));

  assign clr = win_en && col_last && row_last;

  always_comb begin
    state_next = state;
    case (state)
      mrelbp_pkg::idle: begin
        if (col_valid) begin
          state_next = mrelbp_pkg::fill;
        end
      end
      mrelbp_pkg::fill,
      mrelbp_pkg::run: begin
        if (win_en) begin
          if (col_last) begin
            // New row restarts the fill, frame end goes idle
            state_next = row_last ? mrelbp_pkg::idle : mrelbp_pkg::fill;
          end else begin
            state_next = mrelbp_pkg::run;
          end
        end
      end
      default: begin
        state_next = mrelbp_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= mrelbp_pkg::idle;
      win_strobe <= 1'b0;
      row_done   <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      state      <= state_next;
      win_strobe <= win_en;             // Aligned with win_sum
      row_done   <= win_en && col_last;
      frame_done <= clr;
    end
  end

endmodule

//--- ci_r4/r4_sum.sv
`timescale 1ns/1ps

module r4_sum (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 col_valid,
  input  mrelbp_pkg::pix_col_t col,
  input  logic                 win_en,
  input  logic                 clr,
  output logic                 col_full,
  output logic                 col_last,
  output logic                 row_last,
  output mrelbp_pkg::winsum_t  win_sum,
  output mrelbp_pkg::pix_t     centre
);

  mrelbp_pkg::colsum_t col_sum;
  mrelbp_pkg::colsum_t hist [mrelbp_pkg::win_size];      // hist[0] is the newest
  mrelbp_pkg::pix_t    mid_hist [mrelbp_pkg::win_size/2];
  mrelbp_pkg::winsum_t run_sum;
  mrelbp_pkg::winsum_t next_sum;
  mrelbp_pkg::col_idx_t col_cnt;
  mrelbp_pkg::row_idx_t row_cnt;  // Rows of complete columns, 0 is image row 8

  always_comb begin
    col_sum = '0;
    for (int k = 0; k < mrelbp_pkg::win_size; k++) begin
      col_sum = col_sum + mrelbp_pkg::colsum_t'(col.px[k]);
    end
  end

  always_comb begin
    if (col_cnt == '0) begin
      next_sum = mrelbp_pkg::winsum_t'(col_sum);            // Row start reload
    end else if (col_cnt >= mrelbp_pkg::col_idx_t'(mrelbp_pkg::win_size)) begin
      next_sum = run_sum + mrelbp_pkg::winsum_t'(col_sum)
               - mrelbp_pkg::winsum_t'(hist[mrelbp_pkg::win_size-1]);
    end else begin
      next_sum = run_sum + mrelbp_pkg::winsum_t'(col_sum);
    end
  end

  // Counting the incoming column
  assign col_full = col_cnt >= mrelbp_pkg::col_idx_t'(mrelbp_pkg::win_size - 1);
  assign col_last = col_cnt == mrelbp_pkg::col_idx_t'(mrelbp_pkg::img_cols - 1);
  assign row_last = row_cnt ==
                    mrelbp_pkg::row_idx_t'(mrelbp_pkg::img_rows - mrelbp_pkg::win_size);

  always_ff @(posedge clk) begin
    if (col_valid) begin
      hist[0]     <= col_sum;
      mid_hist[0] <= col.px[mrelbp_pkg::win_size/2];
      for (int i = 1; i < mrelbp_pkg::win_size; i++) begin
        hist[i] <= hist[i-1];
      end
      for (int i = 1; i < mrelbp_pkg::win_size / 2; i++) begin
        mid_hist[i] <= mid_hist[i-1];
      end
    end
  end

  // Centre is four columns behind the newest one
  always_ff @(posedge clk) begin
    if (win_en) begin
      win_sum <= next_sum;
      centre  <= mid_hist[mrelbp_pkg::win_size/2 - 1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
      run_sum <= '0;
    end else if (col_valid) begin
      if (clr) begin
        col_cnt <= '0;
        row_cnt <= '0;
        run_sum <= '0;
      end else begin
        run_sum <= next_sum;
        if (col_last) begin
          col_cnt <= '0;
          row_cnt <= row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- common/mrelbp_pkg.sv
package mrelbp_pkg;

  // Frame geometry
  localparam int img_cols = 16;
  localparam int img_rows = 12;

  // Radius 4 window
  localparam int win_size = 9;
  localparam int win_area = win_size * win_size;

  typedef logic [7:0] pix_t;

  // Column max 9 * 255 = 2295
  typedef logic [11:0] colsum_t;

  // Window max 81 * 255 = 20655
  typedef logic [14:0] winsum_t;

  // Centre times 81, same range as the window sum
  typedef logic [14:0] scaled_t;

  typedef logic [3:0] col_idx_t;
  typedef logic [3:0] row_idx_t;

  // One vertical column of the window
  // px[0] is the oldest row, px[win_size-1] the current one
  typedef struct packed {
    pix_t [win_size-1:0] px;
  } pix_col_t;

  typedef enum logic [1:0] {
    idle = 2'd0,  // Waiting for the first column of a frame
    fill = 2'd1,  // Collecting the first columns of a row
    run  = 2'd2   // One window per column
  } ci_state_t;

endpackage

//--- hw/mrelbp_ci_top.sv
`timescale 1ns/1ps

module mrelbp_ci_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pix_valid,
  input  mrelbp_pkg::pix_t pix,
  output logic             ci_valid,
  output logic             ci,
  output logic             row_done,
  output logic             frame_done
);

  logic                 col_valid;
  mrelbp_pkg::pix_col_t col;

  // Pixel stream to 9-pixel columns
  r4_line_buffer u_line_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .pix       (pix),
    .col_valid (col_valid),
    .col       (col)
  );

  mrelbp_ci_r4 u_ci_r4 (
    .clk        (clk),
    .rst_n      (rst_n),
    .col_valid  (col_valid),
    .col        (col),
    .ci_valid   (ci_valid),
    .ci         (ci),
    .row_done   (row_done),
    .frame_done (frame_done)
  );

endmodule

//--- hw/r4_line_buffer.sv
`timescale 1ns/1ps

module r4_line_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pix_valid,
  input  mrelbp_pkg::pix_t     pix,
  output logic                 col_valid,
  output mrelbp_pkg::pix_col_t col
);

  // Eight previous image rows, indexed by rotating slot
  mrelbp_pkg::pix_t mem [mrelbp_pkg::win_size-1][mrelbp_pkg::img_cols];

  mrelbp_pkg::col_idx_t col_cnt;
  mrelbp_pkg::row_idx_t row_cnt;
  logic [2:0]           slot;       // Slot written by the current row
  mrelbp_pkg::pix_col_t col_next;

  // The slot being overwritten holds the row eight above, i.e. the oldest
  always_comb begin
    col_next.px[mrelbp_pkg::win_size-1] = pix;
    for (int k = 0; k < mrelbp_pkg::win_size - 1; k++) begin
      col_next.px[k] = mem[3'(slot + k)][col_cnt];
    end
  end

  always_ff @(posedge clk) begin
    if (pix_valid) begin
      mem[slot][col_cnt] <= pix;
    end
  end

  always_ff @(posedge clk) begin
    if (pix_valid) begin
      col <= col_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt   <= '0;
      row_cnt   <= '0;
      slot      <= '0;
      col_valid <= 1'b0;
    end else begin
      // Only rows 8 and later complete a column
      col_valid <= pix_valid &&
                   (row_cnt >= mrelbp_pkg::row_idx_t'(mrelbp_pkg::win_size - 1));
      if (pix_valid) begin
        if (col_cnt == mrelbp_pkg::col_idx_t'(mrelbp_pkg::img_cols - 1)) begin
          col_cnt <= '0;
          if (row_cnt == mrelbp_pkg::row_idx_t'(mrelbp_pkg::img_rows - 1)) begin
            row_cnt <= '0;          // Frame over, buffer counts as empty
            slot    <= '0;
          end else begin
            row_cnt <= row_cnt + 1'b1;
            slot    <= slot + 1'b1;
          end
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- tests/tb_ci_model.svh
`ifndef TB_CI_MODEL_SVH
`define TB_CI_MODEL_SVH

localparam logic [31:0] lfsr_seed = 32'hdcdb9796;
localparam int win_rad = mrelbp_pkg::win_size / 2;
localparam int wins_per_row = mrelbp_pkg::img_cols - mrelbp_pkg::win_size + 1;
localparam int win_rows = mrelbp_pkg::img_rows - mrelbp_pkg::win_size + 1;
localparam int wins_per_frame = wins_per_row * win_rows;

logic [31:0]      lfsr_state;
mrelbp_pkg::pix_t frame_img [mrelbp_pkg::img_rows][mrelbp_pkg::img_cols];
logic             exp_q [$];

// Taps 32, 22, 2, 1
function automatic logic lfsr_bit();
  logic out;
  logic fb;
  out = lfsr_state[31];
  fb  = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// Centre scaled by the area against the full 9x9 sum
function automatic logic ci_bit(input int y, input int x);
  int sum;
  int scaled;
  sum = 0;
  for (int dy = -win_rad; dy <= win_rad; dy++) begin
    for (int dx = -win_rad; dx <= win_rad; dx++) begin
      sum = sum + int'(frame_img[y+dy][x+dx]);
    end
  end
  scaled = int'(frame_img[y][x]) * mrelbp_pkg::win_area;
  return scaled >= sum;
endfunction

task automatic queue_expected();
  for (int y = win_rad; y < mrelbp_pkg::img_rows - win_rad; y++) begin
    for (int x = win_rad; x < mrelbp_pkg::img_cols - win_rad; x++) begin
      exp_q.push_back(ci_bit(y, x));   // Raster window order
    end
  end
endtask

`endif

//--- tests/tb_mrelbp_ci_top.sv
`timescale 1ns/1ps

module tb_mrelbp_ci_top;

  logic             clk;
  logic             rst_n;
  logic             pix_valid;
  mrelbp_pkg::pix_t pix;
  logic             ci_valid;
  logic             ci;
  logic             row_done;
  logic             frame_done;

  string test_name;
  int    cyc;
  int    value_errs;
  int    other_errs;
  int    timeouts;
  int    win_cnt;
  int    ones_cnt;
  int    row_done_cnt;
  int    frame_done_cnt;
  int    mon_col;
  int    mon_row;
  int    due_q [$];

  `include "tb_ci_model.svh"

  mrelbp_ci_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_valid  (pix_valid),
    .pix        (pix),
    .ci_valid   (ci_valid),
    .ci         (ci),
    .row_done   (row_done),
    .frame_done (frame_done)
  );

  always #20 clk = ~clk;

  // Output monitor on the falling edge
  always @(negedge clk) begin
    logic exp_bit;
    logic exp_row;
    logic exp_frame;
    int   due;
    cyc = cyc + 1;
    if (!rst_n) begin
      assert (!ci_valid && !row_done && !frame_done) else begin
        $display("Output strobe during reset in test %s at cycle %0d", test_name, cyc);
        other_errs++;
      end
      mon_col = 0;
      mon_row = 0;
    end else begin
      if (pix_valid) begin
        if (mon_row >= mrelbp_pkg::win_size - 1 && mon_col >= mrelbp_pkg::win_size - 1) begin
          due_q.push_back(cyc + 3);   // Pixel completes a window
        end
        mon_col = (mon_col + 1) % mrelbp_pkg::img_cols;
        if (mon_col == 0) begin
          mon_row = (mon_row + 1) % mrelbp_pkg::img_rows;
        end
      end
      if (ci_valid) begin
        assert (due_q.size() > 0) else begin
          $display("Unexpected ci_valid in test %s at cycle %0d", test_name, cyc);
          other_errs++;
        end
        if (due_q.size() > 0) begin
          due = due_q.pop_front();
          assert (due == cyc) else begin
            $display("ERR %s latency: expected cycle %0d, actual cycle %0d", test_name, due, cyc);
            value_errs++;
          end
        end
        assert (exp_q.size() > 0) else begin
          $display("No expected bit left for a ci_valid in test %s", test_name);
          other_errs++;
        end
        if (exp_q.size() > 0) begin
          exp_bit = exp_q.pop_front();
          assert (ci == exp_bit) else begin
            $display("ERR %s ci %0d: expected %0b, actual %0b", test_name, win_cnt, exp_bit, ci);
            value_errs++;
          end
        end
        exp_row   = (win_cnt % wins_per_row == wins_per_row - 1);
        exp_frame = (win_cnt == wins_per_frame - 1);
        assert (row_done == exp_row) else begin
          $display("ERR %s row_done at window %0d: expected %0b, actual %0b", test_name,
                   win_cnt, exp_row, row_done);
          value_errs++;
        end
        assert (frame_done == exp_frame) else begin
          $display("ERR %s frame_done at window %0d: expected %0b, actual %0b", test_name,
                   win_cnt, exp_frame, frame_done);
          value_errs++;
        end
        win_cnt++;
        if (ci) ones_cnt++;
        if (row_done) row_done_cnt++;
        if (frame_done) frame_done_cnt++;
      end else begin
        assert (!row_done && !frame_done) else begin
          $display("row_done or frame_done without ci_valid in test %s", test_name);
          other_errs++;
        end
        if (due_q.size() > 0) begin
          assert (due_q[0] > cyc) else begin
            $display("Missing ci_valid in test %s at cycle %0d", test_name, cyc);
            other_errs++;
            due = due_q.pop_front();
          end
        end
      end
    end
  end

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      pix_valid <= 1'b0;
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < mrelbp_pkg::img_rows; r++) begin
      for (int c = 0; c < mrelbp_pkg::img_cols; c++) begin
        frame_img[r][c] = mrelbp_pkg::pix_t'(rand_bits(8));
      end
    end
  endtask

  task automatic fill_constant(input mrelbp_pkg::pix_t v);
    for (int r = 0; r < mrelbp_pkg::img_rows; r++) begin
      for (int c = 0; c < mrelbp_pkg::img_cols; c++) begin
        frame_img[r][c] = v;
      end
    end
  endtask

  // Bright image with dark centres on a checkerboard
  task automatic fill_centre_pattern();
    fill_constant(8'hff);
    for (int r = win_rad; r < mrelbp_pkg::img_rows - win_rad; r++) begin
      for (int c = win_rad; c < mrelbp_pkg::img_cols - win_rad; c++) begin
        if ((r + c) % 2 == 0) frame_img[r][c] = 8'h00;
      end
    end
  endtask

  task automatic send_frame(input logic gaps);
    int n_gap;
    for (int r = 0; r < mrelbp_pkg::img_rows; r++) begin
      for (int c = 0; c < mrelbp_pkg::img_cols; c++) begin
        n_gap = gaps ? int'(rand_bits(2)) : 0;
        idle_cycles(n_gap);
        @(posedge clk);
        pix_valid <= 1'b1;
        pix       <= frame_img[r][c];
      end
    end
    idle_cycles(1);
  endtask

  task automatic wait_frame_end(input int limit);
    int n;
    n = 0;
    while (frame_done_cnt == 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (frame_done_cnt == 0) begin
      $display("Timeout in test %s: no frame_done within %0d cycles", test_name, limit);
      timeouts++;
    end
  endtask

  task automatic run_frame(input string name, input logic gaps);
    test_name      = name;
    win_cnt        = 0;
    ones_cnt       = 0;
    row_done_cnt   = 0;
    frame_done_cnt = 0;
    queue_expected();
    send_frame(gaps);
    wait_frame_end(50);
    idle_cycles(4);
    assert (win_cnt == wins_per_frame) else begin
      $display("ERR %s ci_valid count: expected %0d, actual %0d", name, wins_per_frame, win_cnt);
      value_errs++;
    end
    assert (row_done_cnt == win_rows) else begin
      $display("ERR %s row_done count: expected %0d, actual %0d", name, win_rows, row_done_cnt);
      value_errs++;
    end
    assert (frame_done_cnt == 1) else begin
      $display("ERR %s frame_done count: expected 1, actual %0d", name, frame_done_cnt);
      value_errs++;
    end
    assert (exp_q.size() == 0 && due_q.size() == 0) else begin
      $display("Windows of test %s were never reported", name);
      other_errs++;
    end
    exp_q.delete();
    due_q.delete();
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    pix_valid  = 1'b0;
    pix        = '0;
    cyc        = 0;
    value_errs = 0;
    other_errs = 0;
    timeouts   = 0;
    mon_col    = 0;
    mon_row    = 0;
    lfsr_state = lfsr_seed;
    test_name  = "reset";

    // Pixels offered during reset must not leak through
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      pix_valid <= (i < 7);
      pix       <= mrelbp_pkg::pix_t'(rand_bits(8));
    end
    rst_n <= 1'b1;
    idle_cycles(10);

    fill_random();
    run_frame("random_back_to_back", 1'b0);

    fill_constant(8'hff);
    run_frame("constant", 1'b0);
    assert (ones_cnt == wins_per_frame) else begin
      $display("ERR constant ones: expected %0d, actual %0d", wins_per_frame, ones_cnt);
      value_errs++;
    end

    fill_centre_pattern();
    run_frame("centre_pattern", 1'b0);
    assert (ones_cnt > 0 && ones_cnt < wins_per_frame) else begin
      $display("Pattern test %s did not give both bit values", test_name);
      other_errs++;
    end

    fill_random();
    run_frame("random_gaps", 1'b1);

    fill_random();
    run_frame("two_frames_a", 1'b0);
    fill_random();
    run_frame("two_frames_b", 1'b1);

    $display("Errors: %0d value, %0d other, %0d timeout", value_errs, other_errs, timeouts);
    if (value_errs == 0 && other_errs == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
